// ==== Makefile ====
TOP := tb_mul_array

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

# pass only if the run printed the pass message
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== files.f ====
+incdir+hdl
hdl/mul_pkg.sv
hdl/mul_datapath.sv
hdl/mul_lane.sv
hdl/wb_dispatch.sv
hdl/result_collect.sv
hdl/mul_array_top.sv
tests/mul_array_properties.sv
tests/tb_mul_array.sv

// ==== hdl/mul_array_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module mul_array_top (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`MUL_ADR_W-1:0] wb_adr,
    input  logic [31:0]           wb_dat_w,
    output logic                  wb_ack,
    output logic [31:0]           wb_dat_r
);

    import mul_pkg::*;

    logic [`MUL_LANES-1:0]         start;
    logic [`MUL_LANES-1:0]         busy;
    logic [`MUL_LANES-1:0]         done;
    mul_product_t [`MUL_LANES-1:0] product;
    mul_operand_u                  operand;
    logic                          rd_strobe;
    logic [`MUL_ADR_W-1:0]         rd_adr;

    wb_dispatch i_wb_dispatch (
        .clk       (clk),
        .n_rst     (n_rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .busy      (busy),
        .wb_ack    (wb_ack),
        .start     (start),
        .operand   (operand),
        .rd_strobe (rd_strobe),
        .rd_adr    (rd_adr)
    );

    // all lanes see the same operand, start picks one
    for (genvar i = 0; i < `MUL_LANES; i++) begin : g_lane
        mul_lane i_mul_lane (
            .clk     (clk),
            .n_rst   (n_rst),
            .start   (start[i]),
            .operand (operand),
            .busy    (busy[i]),
            .done    (done[i]),
            .product (product[i])
        );
    end

    result_collect i_result_collect (
        .clk       (clk),
        .n_rst     (n_rst),
        .done      (done),
        .busy      (busy),
        .start     (start),
        .product   (product),
        .rd_strobe (rd_strobe),
        .rd_adr    (rd_adr),
        .wb_dat_r  (wb_dat_r)
    );

endmodule

`default_nettype wire

// ==== hdl/mul_cfg.svh ====
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// operand width, product is twice this
`define MUL_WIDTH 16

// parallel multiplier lanes
`define MUL_LANES 4

// wishbone word address map
`define MUL_ADR_W 4
`define MUL_STATUS_ADR 8

`endif

// ==== hdl/mul_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module mul_datapath (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  load,
    input  logic                  step,
    input  mul_pkg::mul_operand_u operand,
    output logic                  last,
    output mul_pkg::mul_product_t product
);

    import mul_pkg::*;

    localparam int W = `MUL_WIDTH;
    localparam int CNT_W = $clog2(W) + 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(W);
    localparam logic [CNT_W-1:0] CNT_SIGN = CNT_W'(W - 1);

    logic [W-1:0]     mcand_sr;
    logic [CNT_W-1:0] count;
    mul_product_t     mplier_ext;
    mul_product_t     partial;
    mul_product_t     addend;
    mul_product_t     acc;

    // bit counter, also the shift distance
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            count <= '0;
        end else if (load) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    // operand capture and multiplicand shifter
    always_ff @(posedge clk) begin
        if (load) begin
            mplier_ext <= {{W{operand.fields.multiplier[W-1]}}, operand.fields.multiplier};
            mcand_sr   <= operand.fields.multiplicand;
        end else if (step) begin
            mcand_sr <= {1'b0, mcand_sr[W-1:1]};
        end
    end

    // sign bit of the multiplicand has negative weight
    always_comb begin
        partial = mcand_sr[0] ? mplier_ext : '0;
        addend  = (count == CNT_SIGN) ? -partial : partial;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            acc <= '0;
        end else if (step) begin
            acc <= acc + (addend << count);
        end
    end

    assign last    = (count == CNT_LAST);
    assign product = acc;

endmodule

`default_nettype wire

// ==== hdl/mul_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_lane (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  start,
    input  mul_pkg::mul_operand_u operand,
    output logic                  busy,
    output logic                  done,
    output mul_pkg::mul_product_t product
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_LOAD = 2'd1;
    localparam logic [1:0] ST_RUN  = 2'd2;

    logic [1:0] state;
    logic [1:0] state_nxt;
    logic       load;
    logic       step;
    logic       last;

    mul_datapath i_mul_datapath (
        .clk     (clk),
        .n_rst   (n_rst),
        .load    (load),
        .step    (step),
        .operand (operand),
        .last    (last),
        .product (product)
    );

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: if (start) state_nxt = ST_LOAD;
            ST_LOAD: state_nxt = ST_RUN;
            // counter has reached the end, product is final
            ST_RUN:  if (last) state_nxt = ST_IDLE;
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= ST_IDLE;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= (state == ST_RUN) && last;
        end
    end

    assign load = (state == ST_LOAD);
    assign step = (state == ST_RUN) && !last;
    assign busy = (state != ST_IDLE);

endmodule

`default_nettype wire

// ==== hdl/mul_pkg.sv ====
`default_nettype none

`include "mul_cfg.svh"

package mul_pkg;

    // operand halves as seen by a lane
    typedef struct packed {
        logic signed [`MUL_WIDTH-1:0] multiplier;
        logic signed [`MUL_WIDTH-1:0] multiplicand;
    } mul_fields_t;

    // bus word or the two signed halves
    typedef union packed {
        logic [2*`MUL_WIDTH-1:0] raw;
        mul_fields_t             fields;
    } mul_operand_u;

    typedef logic signed [2*`MUL_WIDTH-1:0] mul_product_t;

endpackage

`default_nettype wire

// ==== hdl/result_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module result_collect (
    input  logic                                  clk,
    input  logic                                  n_rst,
    input  logic [`MUL_LANES-1:0]                 done,
    input  logic [`MUL_LANES-1:0]                 busy,
    input  logic [`MUL_LANES-1:0]                 start,
    input  mul_pkg::mul_product_t [`MUL_LANES-1:0] product,
    input  logic                                  rd_strobe,
    input  logic [`MUL_ADR_W-1:0]                 rd_adr,
    output logic [31:0]                           wb_dat_r
);

    import mul_pkg::*;

    localparam int LANE_W = $clog2(`MUL_LANES);
    localparam logic [`MUL_ADR_W-1:0] LANE_END   = `MUL_ADR_W'(`MUL_LANES);
    localparam logic [`MUL_ADR_W-1:0] STATUS_ADR = `MUL_ADR_W'(`MUL_STATUS_ADR);

    mul_product_t [`MUL_LANES-1:0] prod_q;
    logic [`MUL_LANES-1:0]         done_flag;
    logic [31:0]                   rd_word;

    // a restart in the done cycle leaves the flag clear
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            prod_q    <= '0;
            done_flag <= '0;
        end else begin
            for (int i = 0; i < `MUL_LANES; i++) begin
                if (done[i]) begin
                    prod_q[i] <= product[i];
                end
                if (start[i]) begin
                    done_flag[i] <= 1'b0;
                end else if (done[i]) begin
                    done_flag[i] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (rd_adr < LANE_END) begin
            rd_word = prod_q[rd_adr[LANE_W-1:0]];
        end else if (rd_adr == STATUS_ADR) begin
            // busy above the done flags
            rd_word = {{(32 - 2 * `MUL_LANES){1'b0}}, busy, done_flag};
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            wb_dat_r <= '0;
        end else if (rd_strobe) begin
            wb_dat_r <= rd_word;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/wb_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module wb_dispatch (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`MUL_ADR_W-1:0] wb_adr,
    input  logic [31:0]           wb_dat_w,
    input  logic [`MUL_LANES-1:0] busy,
    output logic                  wb_ack,
    output logic [`MUL_LANES-1:0] start,
    output mul_pkg::mul_operand_u operand,
    output logic                  rd_strobe,
    output logic [`MUL_ADR_W-1:0] rd_adr
);

    logic                  req;
    logic                  we_q;
    logic [`MUL_ADR_W-1:0] adr_q;

    // new request, not yet answered
    assign req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            wb_ack <= 1'b0;
            we_q   <= 1'b0;
            adr_q  <= '0;
        end else begin
            wb_ack <= req;
            if (req) begin
                we_q  <= wb_we;
                adr_q <= wb_adr;
            end
        end
    end

    // operand word shared by all lanes
    always_ff @(posedge clk) begin
        if (req) begin
            operand.raw <= wb_dat_w;
        end
    end

    // start during the ack cycle, busy lanes drop the write
    for (genvar i = 0; i < `MUL_LANES; i++) begin : g_start
        assign start[i] = wb_ack && we_q && (adr_q == `MUL_ADR_W'(i)) && !busy[i];
    end

    // read data gets registered on the ack edge
    assign rd_strobe = req && !wb_we;
    assign rd_adr    = wb_adr;

endmodule

`default_nettype wire

// ==== tests/mul_array_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// one checker for both sides, unused inputs are tied low in the bind
module mul_array_properties (
    input logic clk,
    input logic n_rst,
    input logic wb_ack,
    input logic start,
    input logic busy,
    input logic done
);

    // ack is a single cycle pulse
    a_ack_one_cycle: assert property (@(posedge clk) disable iff (!n_rst)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high for more than one cycle");

    a_start_idle: assert property (@(posedge clk) disable iff (!n_rst)
        start |-> !busy)
        else $error("lane started while busy");

    // done rises on the 18th edge after start is taken, seen one edge later
    a_done_after_start: assert property (@(posedge clk) disable iff (!n_rst)
        start |-> ##19 done)
        else $error("done missing 18 cycles after start");

    a_done_has_start: assert property (@(posedge clk) disable iff (!n_rst)
        done |-> $past(start, 19))
        else $error("done without a start 18 cycles earlier");

    a_done_not_busy: assert property (@(posedge clk) disable iff (!n_rst)
        done |-> !busy)
        else $error("lane still busy while done is high");

endmodule

`default_nettype wire

// ==== tests/tb_mul_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_cfg.svh"

module tb_mul_array;

    localparam int W = `MUL_WIDTH;
    localparam int LANES = `MUL_LANES;
    localparam int ACK_TIMEOUT = 16;
    localparam int DONE_POLLS = 64;
    localparam logic [31:0] SEED = 32'h35c4_573f;
    localparam logic [`MUL_ADR_W-1:0] STATUS_ADR = `MUL_ADR_W'(`MUL_STATUS_ADR);
    localparam logic [LANES-1:0] ALL_LANES = '1;

    // +32767, -32767, -32768, 0, -1
    localparam logic [W-1:0] CORNER [5] = '{16'h7fff, 16'h8001, 16'h8000, 16'h0000, 16'hffff};

    logic                  clk;
    logic                  n_rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`MUL_ADR_W-1:0] wb_adr;
    logic [31:0]           wb_dat_w;
    logic                  wb_ack;
    logic [31:0]           wb_dat_r;
    logic [31:0]           rng_state;
    // what each collector register should hold
    logic [31:0]           model_product [LANES];

    mul_array_top i_mul_array_top (
        .clk      (clk),
        .n_rst    (n_rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r)
    );

    bind mul_lane mul_array_properties i_lane_props (
        .clk(clk), .n_rst(n_rst), .wb_ack(1'b0),
        .start(start), .busy(busy), .done(done)
    );

    bind wb_dispatch mul_array_properties i_bus_props (
        .clk(clk), .n_rst(n_rst), .wb_ack(wb_ack),
        .start(1'b0), .busy(1'b0), .done(1'b0)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] expected_product(input logic [W-1:0] mcand,
                                                     input logic [W-1:0] mplier);
        int a;
        int b;
        a = $signed(mcand);
        b = $signed(mplier);
        return 32'(a * b);
    endfunction

    function automatic logic [31:0] status_word(input logic [LANES-1:0] busy_bits,
                                                input logic [LANES-1:0] done_bits);
        return 32'({busy_bits, done_bits});
    endfunction

    task automatic check(input string what, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t: %s: got %h, expected %h", $time, what, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    endtask

    // one classic cycle, returns on the falling edge that sees ack
    task automatic bus_cycle(input logic we, input logic [`MUL_ADR_W-1:0] adr,
                             input logic [31:0] wdata);
        int  n;
        bit  got;
        n   = 0;
        got = 1'b0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        while (!got && n < ACK_TIMEOUT) begin
            @(negedge clk);
            got = wb_ack;
            n++;
        end
        if (!got) begin
            stop_on_timeout($sformatf("no wb_ack for access to address %0d", adr));
        end else begin
            // ack comes one cycle after the request
            check("wb_ack latency in cycles", 32'(n), 32'd1);
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
        end
    endtask

    task automatic wb_write(input logic [`MUL_ADR_W-1:0] adr, input logic [31:0] data);
        bus_cycle(1'b1, adr, data);
    endtask

    task automatic wb_read(input logic [`MUL_ADR_W-1:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0);
        data = wb_dat_r;
    endtask

    // poll status until every lane in mask is done and idle
    task automatic wait_done(input logic [LANES-1:0] mask);
        logic [31:0] st;
        int          n;
        bit          ready;
        n     = 0;
        ready = 1'b0;
        while (!ready && n < DONE_POLLS) begin
            wb_read(STATUS_ADR, st);
            ready = ((st[LANES-1:0] & mask) == mask) && ((st[2*LANES-1:LANES] & mask) == '0);
            n++;
        end
        if (!ready) begin
            stop_on_timeout($sformatf("lanes %b never reported done", mask));
        end
    endtask

    task automatic start_lane(input int lane, input logic [W-1:0] mcand,
                              input logic [W-1:0] mplier);
        wb_write(`MUL_ADR_W'(lane), {mplier, mcand});
    endtask

    task automatic check_products();
        logic [31:0] rd;
        for (int i = 0; i < LANES; i++) begin
            wb_read(`MUL_ADR_W'(i), rd);
            check($sformatf("product of lane %0d", i), rd, model_product[i]);
        end
    endtask

    task automatic test_reset_values();
        logic [31:0] rd;
        wb_read(STATUS_ADR, rd);
        check("status after reset", rd, 32'h0);
        check_products();
    endtask

    task automatic test_corners();
        logic [31:0] rd;
        for (int lane = 0; lane < LANES; lane++) begin
            for (int a = 0; a < 5; a++) begin
                for (int b = 0; b < 5; b++) begin
                    start_lane(lane, CORNER[a], CORNER[b]);
                    wait_done(LANES'(1 << lane));
                    model_product[lane] = expected_product(CORNER[a], CORNER[b]);
                    wb_read(`MUL_ADR_W'(lane), rd);
                    check($sformatf("corner product lane %0d", lane), rd, model_product[lane]);
                    // lanes up to this one have finished, none is busy
                    wb_read(STATUS_ADR, rd);
                    check($sformatf("status after corner on lane %0d", lane), rd,
                          status_word('0, LANES'((2 << lane) - 1)));
                end
            end
        end
    endtask

    // all lanes started back to back and running at once
    task automatic test_parallel();
        logic [31:0] rd;
        for (int lane = 0; lane < LANES; lane++) begin
            rng_state = xorshift(rng_state);
            model_product[lane] = expected_product(rng_state[W-1:0], rng_state[2*W-1:W]);
            start_lane(lane, rng_state[W-1:0], rng_state[2*W-1:W]);
        end
        wb_read(STATUS_ADR, rd);
        check("status with all lanes running", rd, status_word(ALL_LANES, '0));
        wait_done(ALL_LANES);
        check_products();
    endtask

    task automatic test_busy_drop();
        logic [31:0] rd;
        logic [31:0] second;
        rng_state = xorshift(rng_state);
        second    = xorshift(rng_state);
        model_product[1] = expected_product(rng_state[W-1:0], rng_state[2*W-1:W]);
        start_lane(1, rng_state[W-1:0], rng_state[2*W-1:W]);
        start_lane(1, second[W-1:0], second[2*W-1:W]);
        rng_state = second;
        wb_read(STATUS_ADR, rd);
        check("status while lane 1 busy", rd, status_word(LANES'(2), ALL_LANES & ~LANES'(2)));
        wait_done(LANES'(2));
        check_products();
    endtask

    task automatic test_flag_clear();
        logic [31:0] rd;
        logic [31:0] next_product;
        rng_state    = xorshift(rng_state);
        next_product = expected_product(rng_state[W-1:0], rng_state[2*W-1:W]);
        start_lane(2, rng_state[W-1:0], rng_state[2*W-1:W]);
        wb_read(STATUS_ADR, rd);
        check("status after restart of lane 2", rd,
              status_word(LANES'(4), ALL_LANES & ~LANES'(4)));
        // old product stays until the lane finishes
        check_products();
        wait_done(LANES'(4));
        model_product[2] = next_product;
        check_products();
        // writes outside the lanes change nothing
        wb_write(`MUL_ADR_W'(12), 32'h1234_5678);
        wb_write(STATUS_ADR, 32'hffff_ffff);
        wb_read(STATUS_ADR, rd);
        check("status after unmapped writes", rd, status_word('0, ALL_LANES));
        check_products();
        for (int adr = LANES; adr < (1 << `MUL_ADR_W); adr++) begin
            if (adr != `MUL_STATUS_ADR) begin
                wb_read(`MUL_ADR_W'(adr), rd);
                check($sformatf("unmapped read at %0d", adr), rd, 32'h0);
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        n_rst     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        rng_state = SEED;
        for (int i = 0; i < LANES; i++) begin
            model_product[i] = 32'h0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        test_reset_values();
        test_corners();
        test_parallel();
        test_busy_drop();
        test_flag_clear();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
